// File: filelist.f
+incdir+tb
hdl/safe_pad_pkg.sv
hdl/pad_func_mux.sv
hdl/gpio_bank.sv
hdl/pad_select.sv
hdl/safe_domain.sv
tb/tb_safe_domain.sv

// File: hdl/gpio_bank.sv
//******************************
// GPIO side of the pad frame
// Forms GPIO pad drives and synchronises pad levels into gpio_in
//******************************
`timescale 1ns/1ps

module gpio_bank
(
        input  logic                                             ref_clk_i,
        input  logic                                             rst_n_i,

        // Register side
        input  logic [safe_pad_pkg::N_PADS-1:0]                  gpio_out_i,
        input  logic [safe_pad_pkg::N_PADS-1:0]                  gpio_dir_i,

        // Raw pad levels
        input  logic [safe_pad_pkg::N_PADS-1:0]                  pad_in_i,

        output safe_pad_pkg::pad_drive_t [safe_pad_pkg::N_PADS-1:0] gpio_drive_o,
        output logic [safe_pad_pkg::N_PADS-1:0]                  gpio_in_o
);

        // First synchroniser stage, may go metastable
        logic [safe_pad_pkg::N_PADS-1:0] sync_q;
        // Second stage, the GPIO input register
        logic [safe_pad_pkg::N_PADS-1:0] gpio_in_q;

        //******************************
        // Output drive
        //******************************

        always_comb
        begin
                for (int i = 0; i < int'(safe_pad_pkg::N_PADS); i++)
                begin
                        // Direction bit set means the pad is an output
                        gpio_drive_o[i].out = gpio_out_i[i];
                        gpio_drive_o[i].oe  = gpio_dir_i[i];
                end
        end

        //******************************
        // Input synchroniser
        //******************************

        // Pad levels are asynchronous to ref_clk_i
        always_ff @(posedge ref_clk_i or negedge rst_n_i)
        begin
                if (!rst_n_i)
                begin
                        sync_q    <= '0;
                        gpio_in_q <= '0;
                end
                else
                begin
                        sync_q    <= pad_in_i;
                        gpio_in_q <= sync_q;
                end
        end

        // Two edges from pad to register output
        assign gpio_in_o = gpio_in_q;

endmodule

// File: hdl/pad_func_mux.sv
//******************************
// Fixed pin table of the pad frame
// Maps peripheral outputs onto default and alternate pad drives
//******************************
`timescale 1ns/1ps

module pad_func_mux
(
        input  safe_pad_pkg::periph_out_t                        periph_i,
        output safe_pad_pkg::pad_drive_t [safe_pad_pkg::N_PADS-1:0] func_drive_o,
        output safe_pad_pkg::pad_drive_t [safe_pad_pkg::N_PADS-1:0] alt_drive_o
);

        //******************************
        // Default functions
        //******************************

        always_comb
        begin
                // Pads without an output function stay parked at zero
                func_drive_o = '0;

                // Quad SPI data lines, direction set by the SPI master
                for (int k = 0; k < int'(safe_pad_pkg::SPI_LINES); k++)
                begin
                        func_drive_o[safe_pad_pkg::PAD_SPI_SDIO0 + k].out =
                                periph_i.spi_sdo[k];
                        func_drive_o[safe_pad_pkg::PAD_SPI_SDIO0 + k].oe  =
                                periph_i.spi_sdo_oe[k];
                end

                // Chip selects and clock always driven
                func_drive_o[safe_pad_pkg::PAD_SPI_CSN0].out = periph_i.spi_csn[0];
                func_drive_o[safe_pad_pkg::PAD_SPI_CSN0].oe  = 1'b1;
                func_drive_o[safe_pad_pkg::PAD_SPI_CSN1].out = periph_i.spi_csn[1];
                func_drive_o[safe_pad_pkg::PAD_SPI_CSN1].oe  = 1'b1;
                func_drive_o[safe_pad_pkg::PAD_SPI_SCK].out  = periph_i.spi_sck;
                func_drive_o[safe_pad_pkg::PAD_SPI_SCK].oe   = 1'b1;

                // UART rx pad is input only and keeps the zero drive
                func_drive_o[safe_pad_pkg::PAD_UART_TX].out = periph_i.uart_tx;
                func_drive_o[safe_pad_pkg::PAD_UART_TX].oe  = 1'b1;

                // I2C open drain style, enable comes from the controller
                func_drive_o[safe_pad_pkg::PAD_I2C_SDA].out = periph_i.i2c_sda_out;
                func_drive_o[safe_pad_pkg::PAD_I2C_SDA].oe  = periph_i.i2c_sda_oe;
                func_drive_o[safe_pad_pkg::PAD_I2C_SCL].out = periph_i.i2c_scl_out;
                func_drive_o[safe_pad_pkg::PAD_I2C_SCL].oe  = periph_i.i2c_scl_oe;

                // Spare pad has no default function
        end

        //******************************
        // Alternate functions
        //******************************

        always_comb
        begin
                // Most pads have no alternate, same as off
                alt_drive_o = '0;

                // UART tx moved onto the I2C data pad
                alt_drive_o[safe_pad_pkg::PAD_I2C_SDA].out = periph_i.uart_tx;
                alt_drive_o[safe_pad_pkg::PAD_I2C_SDA].oe  = 1'b1;

                // UART rx on the I2C clock pad, input only
                alt_drive_o[safe_pad_pkg::PAD_I2C_SCL].out = 1'b0;
                alt_drive_o[safe_pad_pkg::PAD_I2C_SCL].oe  = 1'b0;

                // Second chip select duplicated on the spare pad
                alt_drive_o[safe_pad_pkg::PAD_SPARE].out = periph_i.spi_csn[1];
                alt_drive_o[safe_pad_pkg::PAD_SPARE].oe  = 1'b1;
        end

endmodule

// File: hdl/pad_select.sv
//******************************
// Per pad source select with registered drive and configuration
// Also routes pad levels back to the peripheral inputs
//******************************
`timescale 1ns/1ps

module pad_select
(
        input  logic                                             ref_clk_i,
        input  logic                                             rst_n_i,

        // Pad control registers
        input  safe_pad_pkg::pad_sel_e [safe_pad_pkg::N_PADS-1:0]   pad_mux_i,
        input  safe_pad_pkg::pad_cfg_t [safe_pad_pkg::N_PADS-1:0]   pad_cfg_i,
        input  safe_pad_pkg::pad_cfg_t [safe_pad_pkg::N_PADS-1:0]   gpio_cfg_i,

        // Candidate drives per pad
        input  safe_pad_pkg::pad_drive_t [safe_pad_pkg::N_PADS-1:0] func_drive_i,
        input  safe_pad_pkg::pad_drive_t [safe_pad_pkg::N_PADS-1:0] alt_drive_i,
        input  safe_pad_pkg::pad_drive_t [safe_pad_pkg::N_PADS-1:0] gpio_drive_i,

        input  logic [safe_pad_pkg::N_PADS-1:0]                  pad_in_i,

        output safe_pad_pkg::pad_drive_t [safe_pad_pkg::N_PADS-1:0] pad_drive_o,
        output safe_pad_pkg::pad_cfg_t [safe_pad_pkg::N_PADS-1:0]   pad_cfg_o,
        output safe_pad_pkg::periph_in_t                         periph_o
);

        // Selected drive and configuration before the register
        safe_pad_pkg::pad_drive_t [safe_pad_pkg::N_PADS-1:0] drive_d;
        safe_pad_pkg::pad_cfg_t   [safe_pad_pkg::N_PADS-1:0] cfg_d;

        // Configuration words kept flat towards the pad ring
        logic [safe_pad_pkg::N_PADS-1:0][safe_pad_pkg::PAD_CFG_W-1:0] cfg_q;

        // Pads whose current select maps a peripheral input
        logic [safe_pad_pkg::N_PADS-1:0]                             uart_rx_map;
        logic [safe_pad_pkg::N_PADS-1:0]                             i2c_sda_map;
        logic [safe_pad_pkg::N_PADS-1:0]                             i2c_scl_map;
        logic [safe_pad_pkg::SPI_LINES-1:0][safe_pad_pkg::N_PADS-1:0] spi_sdi_map;

        // Level of the lowest mapped pad, idle level when none is mapped
        function automatic logic pick_lowest(
                input logic [safe_pad_pkg::N_PADS-1:0] map,
                input logic [safe_pad_pkg::N_PADS-1:0] pins,
                input logic                            idle
        );
                logic level;
                level = idle;
                // Walk downwards so the lowest hit wins
                for (int i = int'(safe_pad_pkg::N_PADS) - 1; i >= 0; i--)
                begin
                        if (map[i])
                        begin
                                level = pins[i];
                        end
                end
                return level;
        endfunction

        //******************************
        // Source select
        //******************************

        always_comb
        begin
                for (int i = 0; i < int'(safe_pad_pkg::N_PADS); i++)
                begin
                        case (pad_mux_i[i])
                                safe_pad_pkg::PAD_SEL_FUNC: drive_d[i] = func_drive_i[i];
                                safe_pad_pkg::PAD_SEL_GPIO: drive_d[i] = gpio_drive_i[i];
                                safe_pad_pkg::PAD_SEL_ALT:  drive_d[i] = alt_drive_i[i];
                                // Parked pad, no level and no enable
                                safe_pad_pkg::PAD_SEL_OFF:  drive_d[i] = '0;
                        endcase

                        // GPIO pads take the GPIO word, all others the pad word
                        if (pad_mux_i[i] == safe_pad_pkg::PAD_SEL_GPIO)
                        begin
                                cfg_d[i] = gpio_cfg_i[i];
                        end
                        else
                        begin
                                cfg_d[i] = pad_cfg_i[i];
                        end
                end
        end

        // One edge from select inputs to the pad ring
        always_ff @(posedge ref_clk_i or negedge rst_n_i)
        begin
                if (!rst_n_i)
                begin
                        pad_drive_o <= '0;
                        cfg_q       <= '0;
                end
                else
                begin
                        pad_drive_o <= drive_d;
                        cfg_q       <= cfg_d;
                end
        end

        assign pad_cfg_o = cfg_q;

        //******************************
        // Input routing
        //******************************

        always_comb
        begin
                uart_rx_map = '0;
                i2c_sda_map = '0;
                i2c_scl_map = '0;
                spi_sdi_map = '0;

                // SPI data line k listens on pad k in default mode
                for (int k = 0; k < int'(safe_pad_pkg::SPI_LINES); k++)
                begin
                        spi_sdi_map[k][safe_pad_pkg::PAD_SPI_SDIO0 + k] =
                                (pad_mux_i[safe_pad_pkg::PAD_SPI_SDIO0 + k] ==
                                 safe_pad_pkg::PAD_SEL_FUNC);
                end

                // UART rx has two possible pads
                uart_rx_map[safe_pad_pkg::PAD_UART_RX] =
                        (pad_mux_i[safe_pad_pkg::PAD_UART_RX] == safe_pad_pkg::PAD_SEL_FUNC);
                uart_rx_map[safe_pad_pkg::PAD_I2C_SCL] =
                        (pad_mux_i[safe_pad_pkg::PAD_I2C_SCL] == safe_pad_pkg::PAD_SEL_ALT);

                // I2C lines only in default mode
                i2c_sda_map[safe_pad_pkg::PAD_I2C_SDA] =
                        (pad_mux_i[safe_pad_pkg::PAD_I2C_SDA] == safe_pad_pkg::PAD_SEL_FUNC);
                i2c_scl_map[safe_pad_pkg::PAD_I2C_SCL] =
                        (pad_mux_i[safe_pad_pkg::PAD_I2C_SCL] == safe_pad_pkg::PAD_SEL_FUNC);
        end

        // Idle high for UART and I2C, low for SPI data
        always_comb
        begin
                periph_o.uart_rx    = pick_lowest(uart_rx_map, pad_in_i, 1'b1);
                periph_o.i2c_sda_in = pick_lowest(i2c_sda_map, pad_in_i, 1'b1);
                periph_o.i2c_scl_in = pick_lowest(i2c_scl_map, pad_in_i, 1'b1);
                for (int k = 0; k < int'(safe_pad_pkg::SPI_LINES); k++)
                begin
                        periph_o.spi_sdi[k] = pick_lowest(spi_sdi_map[k], pad_in_i, 1'b0);
                end
        end

endmodule

// File: hdl/safe_domain.sv
//******************************
// Top of the always-on pad frame controller
// Joins the pin table, the GPIO bank and the pad select stage
//******************************
`timescale 1ns/1ps

module safe_domain
(
        input  logic                                             ref_clk_i,
        input  logic                                             rst_n_i,

        //******************************
        // Pad control registers
        //******************************
        input  safe_pad_pkg::pad_sel_e [safe_pad_pkg::N_PADS-1:0]   pad_mux_i,
        input  safe_pad_pkg::pad_cfg_t [safe_pad_pkg::N_PADS-1:0]   pad_cfg_i,
        input  safe_pad_pkg::pad_cfg_t [safe_pad_pkg::N_PADS-1:0]   gpio_cfg_i,

        // GPIO registers
        input  logic [safe_pad_pkg::N_PADS-1:0]                  gpio_out_i,
        input  logic [safe_pad_pkg::N_PADS-1:0]                  gpio_dir_i,

        // UART, quad SPI and I2C outputs
        input  safe_pad_pkg::periph_out_t                        periph_i,

        //******************************
        // Pad ring
        //******************************
        input  logic [safe_pad_pkg::N_PADS-1:0]                  pad_in_i,
        output safe_pad_pkg::pad_drive_t [safe_pad_pkg::N_PADS-1:0] pad_drive_o,
        output safe_pad_pkg::pad_cfg_t [safe_pad_pkg::N_PADS-1:0]   pad_cfg_o,

        // Back towards the SoC
        output logic [safe_pad_pkg::N_PADS-1:0]                  gpio_in_o,
        output safe_pad_pkg::periph_in_t                         periph_o
);

        // Candidate drives for each pad
        safe_pad_pkg::pad_drive_t [safe_pad_pkg::N_PADS-1:0] func_drive;
        safe_pad_pkg::pad_drive_t [safe_pad_pkg::N_PADS-1:0] alt_drive;
        safe_pad_pkg::pad_drive_t [safe_pad_pkg::N_PADS-1:0] gpio_drive;

        // Pin table, purely combinational
        pad_func_mux pad_func_mux_i
        (
                .periph_i     ( periph_i   ),
                .func_drive_o ( func_drive ),
                .alt_drive_o  ( alt_drive  )
        );

        // GPIO drive and input synchroniser
        gpio_bank gpio_bank_i
        (
                .ref_clk_i    ( ref_clk_i  ),
                .rst_n_i      ( rst_n_i    ),
                .gpio_out_i   ( gpio_out_i ),
                .gpio_dir_i   ( gpio_dir_i ),
                .pad_in_i     ( pad_in_i   ),
                .gpio_drive_o ( gpio_drive ),
                .gpio_in_o    ( gpio_in_o  )
        );

        // Only this stage looks at the select word
        pad_select pad_select_i
        (
                .ref_clk_i    ( ref_clk_i   ),
                .rst_n_i      ( rst_n_i     ),
                .pad_mux_i    ( pad_mux_i   ),
                .pad_cfg_i    ( pad_cfg_i   ),
                .gpio_cfg_i   ( gpio_cfg_i  ),
                .func_drive_i ( func_drive  ),
                .alt_drive_i  ( alt_drive   ),
                .gpio_drive_i ( gpio_drive  ),
                .pad_in_i     ( pad_in_i    ),
                .pad_drive_o  ( pad_drive_o ),
                .pad_cfg_o    ( pad_cfg_o   ),
                .periph_o     ( periph_o    )
        );

endmodule

// File: hdl/safe_pad_pkg.sv
//******************************
// Shared sizes, pin table positions and types of the pad frame
// Every RTL block refers to these by scoped name
//******************************
package safe_pad_pkg;

        //******************************
        // Sizes
        //******************************

        // Pads in the frame
        localparam int unsigned N_PADS    = 12;
        // Bits in one pad configuration word
        localparam int unsigned PAD_CFG_W = 6;
        // Quad SPI data lines
        localparam int unsigned SPI_LINES = 4;

        //******************************
        // Pin table positions
        //******************************

        // First of four consecutive SPI data pads
        localparam int unsigned PAD_SPI_SDIO0 = 0;
        localparam int unsigned PAD_SPI_CSN0  = 4;
        localparam int unsigned PAD_SPI_CSN1  = 5;
        localparam int unsigned PAD_SPI_SCK   = 6;
        localparam int unsigned PAD_UART_RX   = 7;
        localparam int unsigned PAD_UART_TX   = 8;
        // Also carries UART tx as alternate
        localparam int unsigned PAD_I2C_SDA   = 9;
        // Also carries UART rx as alternate
        localparam int unsigned PAD_I2C_SCL   = 10;
        // No default function, SPI csn1 as alternate
        localparam int unsigned PAD_SPARE     = 11;

        //******************************
        // Types
        //******************************

        // Source select of one pad
        typedef enum logic [1:0] {
                PAD_SEL_FUNC = 2'd0,
                PAD_SEL_GPIO = 2'd1,
                PAD_SEL_ALT  = 2'd2,
                PAD_SEL_OFF  = 2'd3
        } pad_sel_e;

        // Output level and output enable of one pad
        typedef struct packed {
                logic out;
                logic oe;
        } pad_drive_t;

        // Electrical configuration of one pad
        typedef struct packed {
                logic       pull_en;
                logic [1:0] drive;
                logic       schmitt;
                logic       slew;
                logic       keeper;
        } pad_cfg_t;

        // Peripheral signals heading out to the pads
        typedef struct packed {
                logic                 uart_tx;
                logic                 spi_sck;
                logic [1:0]           spi_csn;
                logic [SPI_LINES-1:0] spi_sdo;
                logic [SPI_LINES-1:0] spi_sdo_oe;
                logic                 i2c_scl_out;
                logic                 i2c_scl_oe;
                logic                 i2c_sda_out;
                logic                 i2c_sda_oe;
        } periph_out_t;

        // Pad levels returned to the peripherals
        typedef struct packed {
                logic                 uart_rx;
                logic [SPI_LINES-1:0] spi_sdi;
                logic                 i2c_scl_in;
                logic                 i2c_sda_in;
        } periph_in_t;

endpackage

// File: tb/safe_domain_checks.svh
//******************************
// Reference pin table, routing model and assertions of the pad frame
// Included inside the testbench top, uses its signals directly
//******************************
`ifndef SAFE_DOMAIN_CHECKS_SVH
`define SAFE_DOMAIN_CHECKS_SVH

        // Default function of pad p
        function automatic safe_pad_pkg::pad_drive_t func_entry(input int p,
                        input safe_pad_pkg::periph_out_t per);
                safe_pad_pkg::pad_drive_t d;
                d = '0;
                case (p)
                        0, 1, 2, 3:
                        begin
                                d.out = per.spi_sdo[p];
                                d.oe  = per.spi_sdo_oe[p];
                        end
                        4:
                        begin
                                d.out = per.spi_csn[0];
                                d.oe  = 1'b1;
                        end
                        5:
                        begin
                                d.out = per.spi_csn[1];
                                d.oe  = 1'b1;
                        end
                        6:
                        begin
                                d.out = per.spi_sck;
                                d.oe  = 1'b1;
                        end
                        8:
                        begin
                                d.out = per.uart_tx;
                                d.oe  = 1'b1;
                        end
                        9:
                        begin
                                d.out = per.i2c_sda_out;
                                d.oe  = per.i2c_sda_oe;
                        end
                        10:
                        begin
                                d.out = per.i2c_scl_out;
                                d.oe  = per.i2c_scl_oe;
                        end
                        // Pad 7 is input only, pad 11 unused
                        default: d = '0;
                endcase
                return d;
        endfunction

        // Alternate function of pad p, pad 10 is UART rx and drives nothing
        function automatic safe_pad_pkg::pad_drive_t alt_entry(input int p,
                        input safe_pad_pkg::periph_out_t per);
                safe_pad_pkg::pad_drive_t d;
                d = '0;
                if (p == 9)
                begin
                        d.out = per.uart_tx;
                        d.oe  = 1'b1;
                end
                else if (p == 11)
                begin
                        d.out = per.spi_csn[1];
                        d.oe  = 1'b1;
                end
                return d;
        endfunction

        // Expected registered drive of every pad
        function automatic drive_arr_t expect_drive(input sel_arr_t mux,
                        input safe_pad_pkg::periph_out_t per,
                        input logic [11:0] gout, input logic [11:0] gdir);
                drive_arr_t r;
                for (int p = 0; p < 12; p++)
                begin
                        case (mux[p])
                                safe_pad_pkg::PAD_SEL_FUNC: r[p] = func_entry(p, per);
                                safe_pad_pkg::PAD_SEL_GPIO:
                                begin
                                        r[p].out = gout[p];
                                        r[p].oe  = gdir[p];
                                end
                                safe_pad_pkg::PAD_SEL_ALT:  r[p] = alt_entry(p, per);
                                default:                    r[p] = '0;
                        endcase
                end
                return r;
        endfunction

        // GPIO pads take the GPIO word, all others the pad word
        function automatic cfg_arr_t expect_cfg(input sel_arr_t mux,
                        input cfg_arr_t pcfg, input cfg_arr_t gcfg);
                cfg_arr_t r;
                for (int p = 0; p < 12; p++)
                begin
                        r[p] = (mux[p] == safe_pad_pkg::PAD_SEL_GPIO) ? gcfg[p] : pcfg[p];
                end
                return r;
        endfunction

        // Peripheral inputs, idle levels unless a pad maps the function
        function automatic safe_pad_pkg::periph_in_t expect_periph(input sel_arr_t mux,
                        input logic [11:0] pin);
                safe_pad_pkg::periph_in_t r;
                r.uart_rx    = 1'b1;
                r.i2c_sda_in = 1'b1;
                r.i2c_scl_in = 1'b1;
                r.spi_sdi    = '0;
                for (int k = 0; k < 4; k++)
                begin
                        if (mux[k] == safe_pad_pkg::PAD_SEL_FUNC)
                        begin
                                r.spi_sdi[k] = pin[k];
                        end
                end
                // Pad 10 first so that pad 7 overrides it
                if (mux[10] == safe_pad_pkg::PAD_SEL_ALT)
                begin
                        r.uart_rx = pin[10];
                end
                if (mux[7] == safe_pad_pkg::PAD_SEL_FUNC)
                begin
                        r.uart_rx = pin[7];
                end
                if (mux[9] == safe_pad_pkg::PAD_SEL_FUNC)
                begin
                        r.i2c_sda_in = pin[9];
                end
                if (mux[10] == safe_pad_pkg::PAD_SEL_FUNC)
                begin
                        r.i2c_scl_in = pin[10];
                end
                return r;
        endfunction

        //******************************
        // Assertions
        //******************************

        // Registered outputs stay zero in reset
        assert property (@(posedge ref_clk) !rst_n |->
                        (pad_drive == '0 && pad_cfg_out == '0 && gpio_in == '0))
                else report_mismatch("outputs not zero during reset");

        // Still zero at the first edge after release
        assert property (@(posedge ref_clk) (rst_n && !$past(rst_n)) |->
                        (pad_drive == '0 && pad_cfg_out == '0 && gpio_in == '0))
                else report_mismatch("outputs not zero at first edge after reset");

        // One edge from select inputs to the pad drive
        assert property (@(posedge ref_clk) disable iff (!rst_n)
                        $past(rst_n) |-> pad_drive == expect_drive($past(pad_mux),
                                $past(periph), $past(gpio_out), $past(gpio_dir)))
                else report_mismatch("pad drive differs from the pin table");

        assert property (@(posedge ref_clk) disable iff (!rst_n)
                        $past(rst_n) |-> pad_cfg_out == expect_cfg($past(pad_mux),
                                $past(pad_cfg), $past(gpio_cfg)))
                else report_mismatch("pad configuration word differs");

        // Combinational routing, inputs settled since the falling edge
        assert property (@(posedge ref_clk) disable iff (!rst_n)
                        periph_back == expect_periph(pad_mux, pad_in))
                else report_mismatch("peripheral input routing differs");

        // Two edges through the synchroniser
        assert property (@(posedge ref_clk) disable iff (!rst_n)
                        $past(rst_n, 2) |-> gpio_in == $past(pad_in, 2))
                else report_mismatch("gpio_in is not pad_in two edges late");

`endif

// File: tb/tb_safe_domain.sv
//******************************
// Testbench of the pad frame controller
// Random stimulus on the falling edge
// Assertions come from the included checks header
//******************************
`timescale 1ns/1ps

module tb_safe_domain;

        typedef safe_pad_pkg::pad_sel_e   [11:0] sel_arr_t;
        typedef safe_pad_pkg::pad_cfg_t   [11:0] cfg_arr_t;
        typedef safe_pad_pkg::pad_drive_t [11:0] drive_arr_t;

        logic                       ref_clk;
        logic                       rst_n;
        sel_arr_t                   pad_mux;
        cfg_arr_t                   pad_cfg;
        cfg_arr_t                   gpio_cfg;
        logic [11:0]                gpio_out;
        logic [11:0]                gpio_dir;
        safe_pad_pkg::periph_out_t  periph;
        logic [11:0]                pad_in;
        drive_arr_t                 pad_drive;
        cfg_arr_t                   pad_cfg_out;
        logic [11:0]                gpio_in;
        safe_pad_pkg::periph_in_t   periph_back;

        // LFSR state stepped once per bit drawn
        logic [31:0]                lfsr;

        safe_domain DUT
        (
                .ref_clk_i   ( ref_clk     ),
                .rst_n_i     ( rst_n       ),
                .pad_mux_i   ( pad_mux     ),
                .pad_cfg_i   ( pad_cfg     ),
                .gpio_cfg_i  ( gpio_cfg    ),
                .gpio_out_i  ( gpio_out    ),
                .gpio_dir_i  ( gpio_dir    ),
                .periph_i    ( periph      ),
                .pad_in_i    ( pad_in      ),
                .pad_drive_o ( pad_drive   ),
                .pad_cfg_o   ( pad_cfg_out ),
                .gpio_in_o   ( gpio_in     ),
                .periph_o    ( periph_back )
        );

        // 100 ns period
        initial
        begin
                ref_clk = 1'b0;
                forever #50 ref_clk = ~ref_clk;
        end

        task automatic stop_failed();
                $display("Simulation failed");
                $fatal(1);
        endtask

        task automatic report_mismatch(input string msg);
                $display("mismatch at %0t ns: %s", $time, msg);
                stop_failed();
        endtask

        task automatic report_timeout(input string msg);
                $display("Timed out at %0t ns while waiting: %s", $time, msg);
                stop_failed();
        endtask

`include "safe_domain_checks.svh"

        // Taps 32 22 2 1
        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                logic fb;
                fb = s[31] ^ s[21] ^ s[1] ^ s[0];
                return {s[30:0], fb};
        endfunction

        task automatic draw_bits(input int n, output logic [31:0] v);
                v = '0;
                for (int b = 0; b < n; b++)
                begin
                        lfsr = lfsr_step(lfsr);
                        v    = {v[30:0], lfsr[0]};
                end
        endtask

        // New values for every input with selects held at FUNC if asked
        task automatic randomize_inputs(input logic all_func);
                logic [31:0] v;
                for (int p = 0; p < 12; p++)
                begin
                        draw_bits(2, v);
                        pad_mux[p] = all_func ? safe_pad_pkg::PAD_SEL_FUNC
                                              : safe_pad_pkg::pad_sel_e'(v[1:0]);
                        draw_bits(6, v);
                        pad_cfg[p] = v[5:0];
                        draw_bits(6, v);
                        gpio_cfg[p] = v[5:0];
                end
                draw_bits(12, v);
                gpio_out = v[11:0];
                draw_bits(12, v);
                gpio_dir = v[11:0];
                draw_bits(16, v);
                periph = v[15:0];
                draw_bits(12, v);
                pad_in = v[11:0];
        endtask

        task automatic wait_gpio_in(input logic [11:0] target, input int limit);
                int waited;
                waited = 0;
                while (gpio_in !== target)
                begin
                        @(negedge ref_clk);
                        waited++;
                        if (waited > limit)
                        begin
                                report_timeout("gpio_in never reached the held pad levels");
                        end
                end
        endtask

        initial
        begin
                lfsr     = 32'hf197;
                rst_n    = 1'b0;
                pad_mux  = '0;
                pad_cfg  = '0;
                gpio_cfg = '0;
                gpio_out = '0;
                gpio_dir = '0;
                periph   = '0;
                pad_in   = '0;

                // Reset spans four rising edges while random inputs already move
                for (int c = 0; c < 4; c++)
                begin
                        @(negedge ref_clk);
                        randomize_inputs(1'b1);
                end
                rst_n = 1'b1;

                // Default functions on all pads
                for (int c = 0; c < 64; c++)
                begin
                        @(negedge ref_clk);
                        randomize_inputs(1'b1);
                end

                // Mixed selects over GPIO, ALT, OFF and input routing
                for (int c = 0; c < 300; c++)
                begin
                        @(negedge ref_clk);
                        randomize_inputs(1'b0);
                end

                // Held pad levels must come through the synchroniser
                @(negedge ref_clk);
                pad_in = 12'ha5c;
                wait_gpio_in(12'ha5c, 8);
                @(negedge ref_clk);
                $display("Simulation passed");
                $finish;
        end

endmodule
